/* cachePkg.sv */
package cachePkg;

  // address and data widths
  localparam int addrWidth    = 32;
  localparam int dataWidth    = 64;

  // 32-byte line made of four 64-bit words
  localparam int offsetBits   = 5;
  localparam int beatsPerLine = 4;
  localparam int lineWidth    = dataWidth * beatsPerLine;

  // AxPROT for a data access, unprivileged and secure
  localparam logic [2:0] protDataUser = 3'b000;

  // pipeline request, a byte address
  typedef struct packed {
    logic [addrWidth-1:0] addr;
  } cacheReq_t;

  // pipeline response, aligned word and hit flag
  typedef struct packed {
    logic [dataWidth-1:0] data;
    logic                 hit;
  } cacheResp_t;

  // AXI4-Lite read address channel payload
  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic [2:0]           prot;
  } axiLiteAr_t;

  // AXI4-Lite read data channel payload
  typedef struct packed {
    logic [dataWidth-1:0] data;
    logic [1:0]           resp;
  } axiLiteR_t;

endpackage

/* pipeSlice.sv */
`timescale 1ns/1ps
module pipeSlice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     inValid_i,
  output logic     inReady_o,
  input  payload_t inData_i,
  output logic     outValid_o,
  input  logic     outReady_i,
  output payload_t outData_o
);

  logic     mainValid;
  logic     skidValid;
  logic     readyQ;
  logic     inFire;
  logic     mainLoad;
  logic     skidNext;
  payload_t mainData;
  payload_t skidData;

  assign inFire   = inValid_i && readyQ;
  // main entry can take a new beat when empty or draining
  assign mainLoad = outReady_i || !mainValid;
  assign skidNext = mainLoad ? 1'b0 : (skidValid || inFire);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mainValid <= 1'b0;
      skidValid <= 1'b0;
      readyQ    <= 1'b0;
    end else begin
      if (mainLoad) begin
        mainValid <= skidValid || inFire;
      end
      skidValid <= skidNext;
      // ready is registered, so no path from outReady_i
      readyQ    <= !skidNext;
    end
  end

  always_ff @(posedge clk) begin
    if (mainLoad) begin
      mainData <= skidValid ? skidData : inData_i;
    end else if (inFire) begin
      skidData <= inData_i;
    end
  end

  assign inReady_o  = readyQ;
  assign outValid_o = mainValid;
  assign outData_o  = mainData;

endmodule

/* cacheArrays.sv */
`timescale 1ns/1ps
module cacheArrays #(
  parameter int  setBits  = 6,
  localparam int tagWidth = cachePkg::addrWidth - setBits - cachePkg::offsetBits
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // lookup read port
  input  logic                           rdEn_i,
  input  logic [setBits-1:0]             rdSet_i,
  output logic [tagWidth-1:0]            tag0_o,
  output logic [tagWidth-1:0]            tag1_o,
  output logic                           valid0_o,
  output logic                           valid1_o,
  output logic [cachePkg::lineWidth-1:0] line0_o,
  output logic [cachePkg::lineWidth-1:0] line1_o,
  // refill write port
  input  logic                           wrEn_i,
  input  logic                           wrWay_i,
  input  logic [setBits-1:0]             wrSet_i,
  input  logic [tagWidth-1:0]            wrTag_i,
  input  logic [cachePkg::lineWidth-1:0] wrLine_i
);

  localparam int numSets = 1 << setBits;
  localparam int numWays = 2;

  for (genvar w = 0; w < numWays; w++) begin : gWay
    logic [tagWidth-1:0]            tagMem  [numSets];
    logic [cachePkg::lineWidth-1:0] lineMem [numSets];
    logic [numSets-1:0]             validVec;
    logic [tagWidth-1:0]            tagQ;
    logic [cachePkg::lineWidth-1:0] lineQ;
    logic                           validQ;
    logic                           wrHere;

    assign wrHere = wrEn_i && (int'(wrWay_i) == w);

    // tag and line storage, written whole on a fill
    always_ff @(posedge clk) begin
      if (wrHere) begin
        tagMem[wrSet_i]  <= wrTag_i;
        lineMem[wrSet_i] <= wrLine_i;
      end
    end

    always_ff @(posedge clk) begin
      if (rdEn_i) begin
        tagQ  <= tagMem[rdSet_i];
        lineQ <= lineMem[rdSet_i];
      end
    end

    // valid bits start cleared, a fill marks the set
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        validVec <= '0;
        validQ   <= 1'b0;
      end else begin
        if (wrHere) begin
          validVec[wrSet_i] <= 1'b1;
        end
        if (rdEn_i) begin
          validQ <= validVec[rdSet_i];
        end
      end
    end
  end

  assign tag0_o   = gWay[0].tagQ;
  assign tag1_o   = gWay[1].tagQ;
  assign valid0_o = gWay[0].validQ;
  assign valid1_o = gWay[1].validQ;
  assign line0_o  = gWay[0].lineQ;
  assign line1_o  = gWay[1].lineQ;

endmodule

/* cacheCtrl.sv */
`timescale 1ns/1ps
module cacheCtrl #(
  parameter int  setBits  = 6,
  localparam int tagWidth = cachePkg::addrWidth - setBits - cachePkg::offsetBits
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           lkValid_i,
  output logic                           lkReady_o,
  input  cachePkg::cacheReq_t            lkReq_i,
  output logic                           rsValid_o,
  input  logic                           rsReady_i,
  output cachePkg::cacheResp_t           rsData_o,
  output logic                           rdEn_o,
  output logic [setBits-1:0]             rdSet_o,
  input  logic [tagWidth-1:0]            tag0_i,
  input  logic [tagWidth-1:0]            tag1_i,
  input  logic                           valid0_i,
  input  logic                           valid1_i,
  input  logic [cachePkg::lineWidth-1:0] line0_i,
  input  logic [cachePkg::lineWidth-1:0] line1_i,
  output logic                           wrEn_o,
  output logic                           wrWay_o,
  output logic [setBits-1:0]             wrSet_o,
  output logic [tagWidth-1:0]            wrTag_o,
  output logic [cachePkg::lineWidth-1:0] wrLine_o,
  output logic                           fetchValid_o,
  input  logic                           fetchReady_i,
  output logic [cachePkg::addrWidth-1:0] fetchAddr_o,
  input  logic                           beatValid_i,
  input  logic [cachePkg::dataWidth-1:0] beatData_i
);

  localparam int byteBits = $clog2(cachePkg::dataWidth / 8);
  localparam int beatBits = $clog2(cachePkg::beatsPerLine);
  localparam int numSets  = 1 << setBits;

  typedef enum logic [2:0] {sIdle, sLookup, sCompare, sFetch, sRespond} state_t;

  state_t                         state;
  state_t                         stateNext;
  cachePkg::cacheReq_t            reqQ;
  logic [tagWidth-1:0]            reqTag;
  logic [setBits-1:0]             reqSet;
  logic [beatBits-1:0]            reqWord;
  logic                           hit0;
  logic                           hit1;
  logic                           hit;
  logic [cachePkg::lineWidth-1:0] hitLine;
  logic [numSets-1:0]             lruQ;
  logic [beatBits-1:0]            beatCnt;
  logic                           fetchPend;
  logic                           lastBeat;
  logic                           hitDone;
  logic [cachePkg::dataWidth-1:0] lineBuf [cachePkg::beatsPerLine];

  assign reqTag  = reqQ.addr[cachePkg::addrWidth-1 -: tagWidth];
  assign reqSet  = reqQ.addr[cachePkg::offsetBits +: setBits];
  assign reqWord = reqQ.addr[byteBits +: beatBits];

  // tag compare against the latched request
  assign hit0    = valid0_i && (tag0_i == reqTag);
  assign hit1    = valid1_i && (tag1_i == reqTag);
  assign hit     = hit0 || hit1;
  assign hitLine = hit1 ? line1_i : line0_i;
  assign hitDone = (state == sCompare) && hit && rsReady_i;

  // a finished hit frees the controller, so the next lookup is taken at once
  assign lkReady_o = (state == sIdle) || hitDone;

  always_comb begin
    stateNext = state;
    case (state)
      sIdle:    if (lkValid_i) stateNext = sLookup;
      sLookup:  stateNext = sCompare;
      sCompare: begin
        if (!hit) begin
          stateNext = sFetch;
        end else if (rsReady_i) begin
          stateNext = lkValid_i ? sLookup : sIdle;
        end
      end
      sFetch:   if (beatValid_i && lastBeat) stateNext = sRespond;
      sRespond: if (rsReady_i) stateNext = sIdle;
      default:  stateNext = sIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= sIdle;
      beatCnt   <= '0;
      fetchPend <= 1'b0;
      lruQ      <= '0;
    end else begin
      state <= stateNext;
      if ((state == sCompare) && !hit) begin
        beatCnt   <= '0;
        fetchPend <= 1'b0;
      end else if (state == sFetch) begin
        if (fetchValid_o && fetchReady_i) begin
          fetchPend <= 1'b1;
        end
        if (beatValid_i) begin
          fetchPend <= 1'b0;
          beatCnt   <= beatCnt + 1'b1;
        end
      end
      // lru bit names the way to evict next
      if (hitDone) begin
        lruQ[reqSet] <= hit0;
      end else if (wrEn_o) begin
        lruQ[reqSet] <= ~wrWay_o;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lkValid_i && lkReady_o) begin
      reqQ <= lkReq_i;
    end
    if ((state == sFetch) && beatValid_i) begin
      lineBuf[beatCnt] <= beatData_i;
    end
  end

  assign rdEn_o  = (state == sLookup);
  assign rdSet_o = reqSet;

  // refill words go out in rising address order from the line base
  assign lastBeat     = (beatCnt == beatBits'(cachePkg::beatsPerLine - 1));
  assign fetchValid_o = (state == sFetch) && !fetchPend;
  assign fetchAddr_o  = {reqQ.addr[cachePkg::addrWidth-1:cachePkg::offsetBits], beatCnt,
                         {byteBits{1'b0}}};

  // line is written in the cycle of the last beat
  assign wrEn_o  = (state == sFetch) && beatValid_i && lastBeat;
  assign wrWay_o = lruQ[reqSet];
  assign wrSet_o = reqSet;
  assign wrTag_o = reqTag;

  always_comb begin
    for (int i = 0; i < cachePkg::beatsPerLine; i++) begin
      if (i == cachePkg::beatsPerLine - 1) begin
        wrLine_o[i*cachePkg::dataWidth +: cachePkg::dataWidth] = beatData_i;
      end else begin
        wrLine_o[i*cachePkg::dataWidth +: cachePkg::dataWidth] = lineBuf[i];
      end
    end
  end

  assign rsValid_o     = ((state == sCompare) && hit) || (state == sRespond);
  assign rsData_o.hit  = (state == sCompare);
  assign rsData_o.data = (state == sCompare) ?
                         hitLine[reqWord*cachePkg::dataWidth +: cachePkg::dataWidth] :
                         lineBuf[reqWord];

endmodule

/* axiLiteRefill.sv */
`timescale 1ns/1ps
module axiLiteRefill (
  input  logic                           clk,
  input  logic                           rst_n,
  // word fetch from the controller
  input  logic                           fetchValid_i,
  output logic                           fetchReady_o,
  input  logic [cachePkg::addrWidth-1:0] fetchAddr_i,
  output logic                           beatValid_o,
  output logic [cachePkg::dataWidth-1:0] beatData_o,
  // AXI4-Lite read channels
  output logic                           arValid_o,
  input  logic                           arReady_i,
  output cachePkg::axiLiteAr_t           ar_o,
  input  logic                           rValid_i,
  output logic                           rReady_o,
  input  cachePkg::axiLiteR_t            r_i
);

  typedef enum logic [1:0] {sIdle, sAddr, sData} state_t;

  state_t                         state;
  logic [cachePkg::addrWidth-1:0] addrQ;
  logic                           beatQ;
  logic [cachePkg::dataWidth-1:0] dataQ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= sIdle;
      beatQ <= 1'b0;
    end else begin
      beatQ <= 1'b0;
      case (state)
        sIdle: if (fetchValid_i) state <= sAddr;
        sAddr: if (arReady_i) state <= sData;
        sData: begin
          if (rValid_i) begin
            state <= sIdle;
            beatQ <= 1'b1;
          end
        end
        default: state <= sIdle;
      endcase
    end
  end

  // address is held stable while arValid_o waits
  always_ff @(posedge clk) begin
    if ((state == sIdle) && fetchValid_i) begin
      addrQ <= fetchAddr_i;
    end
    // resp is not checked, data fills the line regardless
    if ((state == sData) && rValid_i) begin
      dataQ <= r_i.data;
    end
  end

  assign fetchReady_o = (state == sIdle);
  assign arValid_o    = (state == sAddr);
  assign ar_o.addr    = addrQ;
  assign ar_o.prot    = cachePkg::protDataUser;
  assign rReady_o     = (state == sData);
  assign beatValid_o  = beatQ;
  assign beatData_o   = dataQ;

endmodule

/* cacheTop.sv */
`timescale 1ns/1ps
module cacheTop #(
  parameter int  setBits  = 6,
  localparam int tagWidth = cachePkg::addrWidth - setBits - cachePkg::offsetBits
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 reqValid_i,
  output logic                 reqReady_o,
  input  cachePkg::cacheReq_t  req_i,
  output logic                 respValid_o,
  input  logic                 respReady_i,
  output cachePkg::cacheResp_t resp_o,
  output logic                 arValid_o,
  input  logic                 arReady_i,
  output cachePkg::axiLiteAr_t ar_o,
  input  logic                 rValid_i,
  output logic                 rReady_o,
  input  cachePkg::axiLiteR_t  r_i
);

  // request slice to controller
  logic                           lkValid;
  logic                           lkReady;
  cachePkg::cacheReq_t            lkReq;
  // controller to response slice
  logic                           rsValid;
  logic                           rsReady;
  cachePkg::cacheResp_t           rsData;
  // array ports
  logic                           rdEn;
  logic [setBits-1:0]             rdSet;
  logic [tagWidth-1:0]            tag0;
  logic [tagWidth-1:0]            tag1;
  logic                           valid0;
  logic                           valid1;
  logic [cachePkg::lineWidth-1:0] line0;
  logic [cachePkg::lineWidth-1:0] line1;
  logic                           wrEn;
  logic                           wrWay;
  logic [setBits-1:0]             wrSet;
  logic [tagWidth-1:0]            wrTag;
  logic [cachePkg::lineWidth-1:0] wrLine;
  // refill fetch
  logic                           fetchValid;
  logic                           fetchReady;
  logic [cachePkg::addrWidth-1:0] fetchAddr;
  logic                           beatValid;
  logic [cachePkg::dataWidth-1:0] beatData;

  pipeSlice #(.payload_t(cachePkg::cacheReq_t)) i_reqSlice (
    .clk, .rst_n,
    .inValid_i (reqValid_i), .inReady_o (reqReady_o), .inData_i (req_i),
    .outValid_o(lkValid),    .outReady_i(lkReady),    .outData_o(lkReq)
  );

  cacheCtrl #(.setBits(setBits)) i_ctrl (
    .clk, .rst_n,
    .lkValid_i(lkValid), .lkReady_o(lkReady), .lkReq_i(lkReq),
    .rsValid_o(rsValid), .rsReady_i(rsReady), .rsData_o(rsData),
    .rdEn_o(rdEn), .rdSet_o(rdSet), .tag0_i(tag0), .tag1_i(tag1),
    .valid0_i(valid0), .valid1_i(valid1), .line0_i(line0), .line1_i(line1),
    .wrEn_o(wrEn), .wrWay_o(wrWay), .wrSet_o(wrSet), .wrTag_o(wrTag), .wrLine_o(wrLine),
    .fetchValid_o(fetchValid), .fetchReady_i(fetchReady), .fetchAddr_o(fetchAddr),
    .beatValid_i(beatValid), .beatData_i(beatData)
  );

  cacheArrays #(.setBits(setBits)) i_arrays (
    .clk, .rst_n,
    .rdEn_i(rdEn), .rdSet_i(rdSet), .tag0_o(tag0), .tag1_o(tag1),
    .valid0_o(valid0), .valid1_o(valid1), .line0_o(line0), .line1_o(line1),
    .wrEn_i(wrEn), .wrWay_i(wrWay), .wrSet_i(wrSet), .wrTag_i(wrTag), .wrLine_i(wrLine)
  );

  axiLiteRefill i_refill (
    .clk, .rst_n,
    .fetchValid_i(fetchValid), .fetchReady_o(fetchReady), .fetchAddr_i(fetchAddr),
    .beatValid_o(beatValid), .beatData_o(beatData),
    .arValid_o, .arReady_i, .ar_o,
    .rValid_i, .rReady_o, .r_i
  );

  pipeSlice #(.payload_t(cachePkg::cacheResp_t)) i_respSlice (
    .clk, .rst_n,
    .inValid_i (rsValid),     .inReady_o (rsReady),     .inData_i (rsData),
    .outValid_o(respValid_o), .outReady_i(respReady_i), .outData_o(resp_o)
  );

endmodule

/* tbAxiMem.sv */
`timescale 1ns/1ps
module tbAxiMem (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 arValid_i,
  output logic                 arReady_o,
  input  cachePkg::axiLiteAr_t ar_i,
  output logic                 rValid_o,
  input  logic                 rReady_i,
  output cachePkg::axiLiteR_t  r_o
);

  logic [cachePkg::addrWidth-1:0] wordAddr;
  int                             delay;

  // one read at a time, outputs change 1 ns after the rising edge
  initial begin
    arReady_o = 1'b0;
    rValid_o  = 1'b0;
    r_o       = '0;
    forever begin
      @(negedge clk);
      if (rst_n && arValid_i) begin
        // accept the address after a random wait
        delay = int'($urandom_range(3));
        repeat (delay) @(posedge clk);
        @(posedge clk);
        #1;
        arReady_o = 1'b1;
        wordAddr  = {ar_i.addr[31:3], 3'b000};
        @(posedge clk);
        #1;
        arReady_o = 1'b0;
        // data follows after another random wait
        delay = int'($urandom_range(3));
        if (delay > 0) begin
          repeat (delay) @(posedge clk);
          #1;
        end
        rValid_o = 1'b1;
        // upper half is the complement of the word address
        r_o.data = {~wordAddr, wordAddr};
        // an occasional SLVERR, the data is still valid for the fill
        r_o.resp = ($urandom_range(3) == 0) ? 2'b10 : 2'b00;
        do begin
          @(negedge clk);
        end while (!rReady_i);
        @(posedge clk);
        #1;
        rValid_o = 1'b0;
      end
    end
  end

endmodule

/* tbCacheTop.sv */
`timescale 1ns/1ps
module tbCacheTop;

  localparam int     setBits    = 6;
  localparam int     numSets    = 1 << setBits;
  localparam int     tagWidth   = cachePkg::addrWidth - setBits - cachePkg::offsetBits;
  localparam int     numReqs    = 400;
  localparam int     clkPeriod  = 8;
  localparam int     missCycles = 40;
  localparam longint timeoutNs  = longint'(numReqs * missCycles + 1000) * clkPeriod;

  logic                 clk;
  logic                 rst_n;
  logic                 reqValid;
  logic                 reqReady;
  cachePkg::cacheReq_t  req;
  logic                 respValid;
  logic                 respReady;
  cachePkg::cacheResp_t resp;
  logic                 arValid;
  logic                 arReady;
  cachePkg::axiLiteAr_t ar;
  logic                 rValid;
  logic                 rReady;
  cachePkg::axiLiteR_t  r;

  // reference model of the two-way cache
  logic [tagWidth-1:0]  modelTag   [2][numSets];
  logic                 modelValid [2][numSets];
  logic                 modelLru   [numSets];
  cachePkg::cacheResp_t expResp [$];
  logic [31:0]          expAr   [$];
  int                   arCount;
  int                   expArCount;
  int                   respCount;

  cacheTop #(.setBits(setBits)) i_dut (
    .clk, .rst_n,
    .reqValid_i(reqValid), .reqReady_o(reqReady), .req_i(req),
    .respValid_o(respValid), .respReady_i(respReady), .resp_o(resp),
    .arValid_o(arValid), .arReady_i(arReady), .ar_o(ar),
    .rValid_i(rValid), .rReady_o(rReady), .r_i(r)
  );

  tbAxiMem i_mem (
    .clk, .rst_n,
    .arValid_i(arValid), .arReady_o(arReady), .ar_i(ar),
    .rValid_o(rValid), .rReady_i(rReady), .r_o(r)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (expected !== actual) begin
      abortRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // update the model for one accepted request and queue what it predicts
  task automatic predictAccess(input logic [31:0] addr);
    logic [setBits-1:0]   setIdx;
    logic [tagWidth-1:0]  tag;
    logic [31:0]          wordAddr;
    logic [31:0]          lineBase;
    logic                 hit0;
    logic                 hit1;
    logic                 way;
    cachePkg::cacheResp_t exp;
    setIdx   = addr[cachePkg::offsetBits +: setBits];
    tag      = addr[31 -: tagWidth];
    wordAddr = {addr[31:3], 3'b000};
    lineBase = {addr[31:5], 5'b00000};
    hit0     = modelValid[0][setIdx] && (modelTag[0][setIdx] == tag);
    hit1     = modelValid[1][setIdx] && (modelTag[1][setIdx] == tag);
    exp.data = {~wordAddr, wordAddr};
    exp.hit  = hit0 || hit1;
    if (exp.hit) begin
      // the way not hit becomes the next victim
      modelLru[setIdx] = hit0 ? 1'b1 : 1'b0;
    end else begin
      way                   = modelLru[setIdx];
      modelTag[way][setIdx]   = tag;
      modelValid[way][setIdx] = 1'b1;
      modelLru[setIdx]        = ~way;
      for (int i = 0; i < cachePkg::beatsPerLine; i++) begin
        expAr.push_back(lineBase + 32'(i * 8));
      end
      expArCount += cachePkg::beatsPerLine;
    end
    expResp.push_back(exp);
  endtask

  // repeats, same-line words, or a new line from a small tag pool over three sets
  function automatic logic [31:0] nextAddr(input logic [31:0] prevAddr);
    int                  mode;
    logic [setBits-1:0]  setIdx;
    logic [tagWidth-1:0] tag;
    mode = int'($urandom_range(3));
    if (mode == 0) begin
      return prevAddr;
    end else if (mode == 1) begin
      return {prevAddr[31:5], 2'($urandom_range(3)), 3'($urandom_range(7))};
    end
    setIdx = setBits'($urandom_range(2) * 21);
    tag    = tagWidth'(32'h155 + $urandom_range(3) * 32'h40);
    return {tag, setIdx, 2'($urandom_range(3)), 3'($urandom_range(7))};
  endfunction

  task automatic issueRequest(input logic [31:0] addr);
    req.addr = addr;
    reqValid = 1'b1;
    do begin
      @(negedge clk);
    end while (!reqReady);
    predictAccess(addr);
    @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    #1;
    respReady = ($urandom_range(3) != 0);
  end

  always @(negedge clk) begin : respMonitor
    cachePkg::cacheResp_t exp;
    if (!rst_n) begin
      checkValue("reset respValid", 64'(0), 64'(respValid));
      checkValue("reset reqReady", 64'(0), 64'(reqReady));
    end else if (respValid && respReady) begin
      if (expResp.size() == 0) begin
        abortRun("A response came back with no request outstanding.");
      end else begin
        exp = expResp.pop_front();
        checkValue($sformatf("resp %0d data", respCount), exp.data, resp.data);
        checkValue($sformatf("resp %0d hit", respCount), 64'(exp.hit), 64'(resp.hit));
        respCount++;
      end
    end
  end

  always @(negedge clk) begin : arMonitor
    if (!rst_n) begin
      checkValue("reset arValid", 64'(0), 64'(arValid));
      checkValue("reset rReady", 64'(0), 64'(rReady));
    end else if (arValid) begin
      if (expAr.size() == 0) begin
        abortRun("The cache raised a read address that no predicted miss explains.");
      end else if (arReady) begin
        checkValue($sformatf("ar %0d addr", arCount), 64'(expAr.pop_front()), 64'(ar.addr));
        checkValue($sformatf("ar %0d prot", arCount), 64'(0), 64'(ar.prot));
        arCount++;
      end
    end
  end

  initial begin
    #(timeoutNs);
    abortRun("Timeout: not all responses arrived in time.");
  end

  initial begin
    logic [31:0] addr;
    int          gap;
    void'($urandom(52514));
    clk        = 1'b0;
    rst_n      = 1'b0;
    reqValid   = 1'b0;
    req        = '0;
    respReady  = 1'b0;
    arCount    = 0;
    expArCount = 0;
    respCount  = 0;
    for (int s = 0; s < numSets; s++) begin
      modelValid[0][s] = 1'b0;
      modelValid[1][s] = 1'b0;
      modelTag[0][s]   = '0;
      modelTag[1][s]   = '0;
      modelLru[s]      = 1'b0;
    end
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    addr = '0;
    for (int n = 0; n < numReqs; n++) begin
      gap = int'($urandom_range(3));
      if (gap > 1) begin
        reqValid = 1'b0;
        repeat (gap - 1) @(posedge clk);
        #1;
      end
      addr = nextAddr(addr);
      issueRequest(addr);
    end
    reqValid = 1'b0;
    wait (respCount == numReqs);
    repeat (4) @(negedge clk);
    checkValue("ar total", 64'(expArCount), 64'(arCount));
    // nothing may be left waiting once every request has been answered
    checkValue("extra resp", 64'(0), 64'(respValid));
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* cacheTop.f */
cachePkg.sv
pipeSlice.sv
cacheArrays.sv
cacheCtrl.sv
axiLiteRefill.sv
cacheTop.sv
tbAxiMem.sv
tbCacheTop.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module tbCacheTop -f cacheTop.f \
  && ./obj_dir/VtbCacheTop > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation PASSED" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
